//--- Makefile
TOP := exePipeTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f compile.f -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx '\*\* PASS \*\*'

lint:
	verilator --lint-only -Wall --timing --top-module exePipeTop -f compile.f

clean:
	rm -rf obj_dir

//--- compile.f
+incdir+design
design/exePkg.sv
design/exMemIf.sv
design/alu.sv
design/condUnit.sv
design/forwardUnit.sv
design/execute.sv
design/memWriteback.sv
design/exePipeTop.sv
verif/exePipeTb.sv

//--- design/alu.sv
`include "exeSettings.svh"

module alu (
	input  logic [`DATA_WIDTH-1:0] inputA,
	input  logic [`DATA_WIDTH-1:0] inputB,
	input  logic [`DATA_WIDTH-1:0] inputC,
	input  exePkg::aluOp           aluControl,
	output logic [`DATA_WIDTH-1:0] result,
	output exePkg::aluFlags        flags
);
	import exePkg::*;

	localparam int MSB = `DATA_WIDTH - 1;

	logic                   isSub;
	logic                   isArith;
	logic [`DATA_WIDTH-1:0] operandB;
	logic [`DATA_WIDTH:0]   sum;
	logic [`DATA_WIDTH-1:0] product;

	assign isSub   = (aluControl == SUB);
	assign isArith = (aluControl == ADD) || isSub;

	// one adder for add and subtract, b inverted plus carry in
	assign operandB = isSub ? ~inputB : inputB;
	assign sum      = {1'b0, inputA} + {1'b0, operandB} + {{`DATA_WIDTH{1'b0}}, isSub};
	assign product  = inputA * inputB;  // low half only

	always_comb begin
		case (aluControl)
			ADD, SUB: result = sum[MSB:0];
			AND:      result = inputA & inputB;
			ORR:      result = inputA | inputB;
			EOR:      result = inputA ^ inputB;
			MOV:      result = inputB;
			MUL:      result = product;
			MLA:      result = product + inputC;  // accumulate
			default:  result = '0;
		endcase
	end

	always_comb begin
		flags.n = result[MSB];
		flags.z = (result == '0);
		// carry is "no borrow" on subtract, as on ARM
		flags.c = isArith && sum[`DATA_WIDTH];
		// overflow when both addends agree in sign and the sum does not
		flags.v = isArith && (inputA[MSB] == operandB[MSB]) && (sum[MSB] != inputA[MSB]);
	end

endmodule

//--- design/condUnit.sv
module condUnit (
	input  logic            Clk,
	input  logic            reset,
	input  logic            instrValid,
	input  exePkg::condCode cond,
	input  exePkg::aluFlags aluFlagsIn,
	input  logic [1:0]      flagWrite,
	output logic            condEx,
	output exePkg::aluFlags flags
);
	import exePkg::*;

	logic [1:0] flagLoad;  // gated write enables, NZ and CV

	// condition checked against the flags held from earlier instructions
	always_comb begin
		case (cond)
			EQ:      condEx = flags.z;
			NE:      condEx = !flags.z;
			CS:      condEx = flags.c;
			CC:      condEx = !flags.c;
			MI:      condEx = flags.n;
			PL:      condEx = !flags.n;
			VS:      condEx = flags.v;
			VC:      condEx = !flags.v;
			HI:      condEx = flags.c && !flags.z;
			LS:      condEx = !flags.c || flags.z;
			GE:      condEx = (flags.n == flags.v);
			LT:      condEx = (flags.n != flags.v);
			GT:      condEx = !flags.z && (flags.n == flags.v);
			LE:      condEx = flags.z || (flags.n != flags.v);
			AL:      condEx = 1'b1;
			default: condEx = 1'b1;  // unconditional space
		endcase
	end

	assign flagLoad = (instrValid && condEx) ? flagWrite : 2'b00;

	always_ff @(posedge Clk) begin
		if (reset) begin
			flags <= '0;
		end else begin
			if (flagLoad[1]) begin
				flags.n <= aluFlagsIn.n;
				flags.z <= aluFlagsIn.z;
			end
			if (flagLoad[0]) begin
				flags.c <= aluFlagsIn.c;
				flags.v <= aluFlagsIn.v;
			end
		end
	end

	// bubbles, squashed and non-flag-setting instructions keep NZCV
	flagsHold: assert property (
		@(posedge Clk) disable iff (reset)
		!(instrValid && condEx && (flagWrite != 2'b00)) |=> $stable(flags)
	) else $error("flags changed without a flag-setting instruction");

endmodule

//--- design/exMemIf.sv
`include "exeSettings.svh"

interface exMemIf;

	logic [`DATA_WIDTH-1:0]     aluResultM;
	logic [`DATA_WIDTH-1:0]     writeDataM;  // forwarded store data
	logic [`REG_ADDR_WIDTH-1:0] wa3M;
	logic                       regWriteM;
	logic                       memToRegM;
	logic                       memWriteM;
	logic                       pcSrcM;

	modport producer (
		output aluResultM,
		output writeDataM,
		output wa3M,
		output regWriteM,
		output memToRegM,
		output memWriteM,
		output pcSrcM
	);

	modport consumer (
		input aluResultM,
		input writeDataM,
		input wa3M,
		input regWriteM,
		input memToRegM,
		input memWriteM,
		input pcSrcM
	);

endinterface

//--- design/exePipeTop.sv
`include "exeSettings.svh"

module exePipeTop (
	input  logic                       Clk,
	input  logic                       reset,
	input  logic                       instrValid,
	input  logic                       regWrite,
	input  logic                       pcSrc,
	input  logic                       branch,
	input  logic                       aluSrc,
	input  logic                       memToReg,
	input  logic                       memWrite,
	input  logic [1:0]                 flagWrite,
	input  exePkg::aluOp               aluControl,
	input  exePkg::condCode            cond,
	input  logic [`DATA_WIDTH-1:0]     dataA,
	input  logic [`DATA_WIDTH-1:0]     dataB,
	input  logic [`DATA_WIDTH-1:0]     dataC,
	input  logic [`DATA_WIDTH-1:0]     ext,
	input  logic [`REG_ADDR_WIDTH-1:0] wa3,
	input  logic [`REG_ADDR_WIDTH-1:0] ra1E,
	input  logic [`REG_ADDR_WIDTH-1:0] ra2E,
	output logic [`DATA_WIDTH-1:0]     aluResult,
	output logic                       branchTaken,
	output logic [3:0]                 flags,  // NZCV
	output logic [`DATA_WIDTH-1:0]     resultW,
	output logic [`REG_ADDR_WIDTH-1:0] wa3W,
	output logic                       regWriteW,
	output logic                       pcSrcW
);
	import exePkg::*;

	fwdSel forwardA;
	fwdSel forwardB;

	exMemIf exMemBus ();

	forwardUnit forwardUnit_i (
		.ra1E     (ra1E),
		.ra2E     (ra2E),
		.wa3M     (exMemBus.wa3M),
		.regWriteM(exMemBus.regWriteM),
		.wa3W     (wa3W),
		.regWriteW(regWriteW),
		.forwardA (forwardA),
		.forwardB (forwardB)
	);

	execute execute_i (
		.Clk        (Clk),
		.reset      (reset),
		.instrValid (instrValid),
		.regWrite   (regWrite),
		.pcSrc      (pcSrc),
		.branch     (branch),
		.aluSrc     (aluSrc),
		.memToReg   (memToReg),
		.memWrite   (memWrite),
		.flagWrite  (flagWrite),
		.aluControl (aluControl),
		.cond       (cond),
		.forwardA   (forwardA),
		.forwardB   (forwardB),
		.dataA      (dataA),
		.dataB      (dataB),
		.dataC      (dataC),
		.ext        (ext),
		.resultW    (resultW),
		.wa3        (wa3),
		.aluResult  (aluResult),
		.branchTaken(branchTaken),
		.flags      (flags),
		.exMem      (exMemBus.producer)
	);

	memWriteback memWriteback_i (
		.Clk      (Clk),
		.reset    (reset),
		.exMem    (exMemBus.consumer),
		.resultW  (resultW),
		.wa3W     (wa3W),
		.regWriteW(regWriteW),
		.pcSrcW   (pcSrcW)
	);

endmodule

//--- design/exePkg.sv
package exePkg;

	// alu operation select
	typedef enum logic [3:0] {
		ADD = 4'd0,
		SUB = 4'd1,
		AND = 4'd2,
		ORR = 4'd3,
		EOR = 4'd4,
		MOV = 4'd5,
		MUL = 4'd6,
		MLA = 4'd7  // a * b + c
	} aluOp;

	// ARM condition field encoding
	typedef enum logic [3:0] {
		EQ = 4'b0000,
		NE = 4'b0001,
		CS = 4'b0010,
		CC = 4'b0011,
		MI = 4'b0100,
		PL = 4'b0101,
		VS = 4'b0110,
		VC = 4'b0111,
		HI = 4'b1000,
		LS = 4'b1001,
		GE = 4'b1010,
		LT = 4'b1011,
		GT = 4'b1100,
		LE = 4'b1101,
		AL = 4'b1110
	} condCode;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} aluFlags;

	typedef enum logic [1:0] {
		FWD_REG = 2'b00,
		FWD_WB  = 2'b01,
		FWD_MEM = 2'b10
	} fwdSel;

endpackage

//--- design/exeSettings.svh
`ifndef EXE_SETTINGS_SVH
`define EXE_SETTINGS_SVH

// datapath and register file geometry
`define DATA_WIDTH     32
`define REG_ADDR_WIDTH 4

// data memory size in words
`define DMEM_DEPTH     64

`endif

//--- design/execute.sv
`include "exeSettings.svh"

module execute (
	input  logic                       Clk,
	input  logic                       reset,
	input  logic                       instrValid,
	input  logic                       regWrite,
	input  logic                       pcSrc,
	input  logic                       branch,
	input  logic                       aluSrc,
	input  logic                       memToReg,
	input  logic                       memWrite,
	input  logic [1:0]                 flagWrite,
	input  exePkg::aluOp               aluControl,
	input  exePkg::condCode            cond,
	input  exePkg::fwdSel              forwardA,
	input  exePkg::fwdSel              forwardB,
	input  logic [`DATA_WIDTH-1:0]     dataA,
	input  logic [`DATA_WIDTH-1:0]     dataB,
	input  logic [`DATA_WIDTH-1:0]     dataC,
	input  logic [`DATA_WIDTH-1:0]     ext,
	input  logic [`DATA_WIDTH-1:0]     resultW,
	input  logic [`REG_ADDR_WIDTH-1:0] wa3,
	output logic [`DATA_WIDTH-1:0]     aluResult,
	output logic                       branchTaken,
	output exePkg::aluFlags            flags,
	exMemIf.producer                   exMem
);
	import exePkg::*;

	logic [`DATA_WIDTH-1:0] srcA;
	logic [`DATA_WIDTH-1:0] fwdB;  // also the store data
	logic [`DATA_WIDTH-1:0] srcB;
	aluFlags                aluFlagsE;
	logic                   condEx;
	logic                   execOk;

	function automatic logic [`DATA_WIDTH-1:0] fwdMux(
		input fwdSel                  sel,
		input logic [`DATA_WIDTH-1:0] regVal,
		input logic [`DATA_WIDTH-1:0] wbVal,
		input logic [`DATA_WIDTH-1:0] memVal
	);
		case (sel)
			FWD_WB:  return wbVal;
			FWD_MEM: return memVal;
			default: return regVal;
		endcase
	endfunction

	assign srcA = fwdMux(forwardA, dataA, resultW, exMem.aluResultM);
	assign fwdB = fwdMux(forwardB, dataB, resultW, exMem.aluResultM);
	assign srcB = aluSrc ? ext : fwdB;  // immediate after forwarding

	alu alu_i (
		.inputA    (srcA),
		.inputB    (srcB),
		.inputC    (dataC),
		.aluControl(aluControl),
		.result    (aluResult),
		.flags     (aluFlagsE)
	);

	condUnit condUnit_i (
		.Clk       (Clk),
		.reset     (reset),
		.instrValid(instrValid),
		.cond      (cond),
		.aluFlagsIn(aluFlagsE),
		.flagWrite (flagWrite),
		.condEx    (condEx),
		.flags     (flags)
	);

	assign execOk      = instrValid && condEx;
	assign branchTaken = branch && execOk;

	// EX/MEM controls
	always_ff @(posedge Clk) begin
		if (reset) begin
			exMem.regWriteM <= 1'b0;
			exMem.memWriteM <= 1'b0;
			exMem.pcSrcM    <= 1'b0;
			exMem.memToRegM <= 1'b0;
		end else begin
			exMem.regWriteM <= regWrite && execOk;
			exMem.memWriteM <= memWrite && execOk;
			exMem.pcSrcM    <= pcSrc && execOk;
			exMem.memToRegM <= memToReg;
		end
	end

	always_ff @(posedge Clk) begin
		exMem.aluResultM <= aluResult;
		exMem.writeDataM <= fwdB;
		exMem.wa3M       <= wa3;
	end

	// a store never also loads into a register
	loadStoreExcl: assert property (
		@(posedge Clk) disable iff (reset)
		exMem.memWriteM |-> !(exMem.regWriteM && exMem.memToRegM)
	) else $error("store and load writeback in the same MEM slot");

endmodule

//--- design/forwardUnit.sv
`include "exeSettings.svh"

module forwardUnit (
	input  logic [`REG_ADDR_WIDTH-1:0] ra1E,
	input  logic [`REG_ADDR_WIDTH-1:0] ra2E,
	input  logic [`REG_ADDR_WIDTH-1:0] wa3M,
	input  logic                       regWriteM,
	input  logic [`REG_ADDR_WIDTH-1:0] wa3W,
	input  logic                       regWriteW,
	output exePkg::fwdSel              forwardA,
	output exePkg::fwdSel              forwardB
);
	import exePkg::*;

	localparam logic [`REG_ADDR_WIDTH-1:0] PC_REG = '1;  // r15

	function automatic fwdSel pickSource(input logic [`REG_ADDR_WIDTH-1:0] src);
		if (src == PC_REG) begin
			return FWD_REG;  // pc reads never forwarded
		end else if (regWriteM && (wa3M == src)) begin
			return FWD_MEM;  // youngest value wins
		end else if (regWriteW && (wa3W == src)) begin
			return FWD_WB;
		end
		return FWD_REG;
	endfunction

	assign forwardA = pickSource(ra1E);
	assign forwardB = pickSource(ra2E);

endmodule

//--- design/memWriteback.sv
`include "exeSettings.svh"

module memWriteback (
	input  logic                       Clk,
	input  logic                       reset,
	exMemIf.consumer                   exMem,
	output logic [`DATA_WIDTH-1:0]     resultW,
	output logic [`REG_ADDR_WIDTH-1:0] wa3W,
	output logic                       regWriteW,
	output logic                       pcSrcW
);

	localparam int ADDR_BITS = $clog2(`DMEM_DEPTH);

	logic [`DATA_WIDTH-1:0] dataMem [`DMEM_DEPTH];
	logic [ADDR_BITS-1:0]   wordAddr;
	logic [`DATA_WIDTH-1:0] readDataM;
	logic [`DATA_WIDTH-1:0] readDataW;
	logic [`DATA_WIDTH-1:0] aluResultW;
	logic                   memToRegW;

	// byte address in, drop the two low bits
	assign wordAddr  = exMem.aluResultM[ADDR_BITS+1:2];
	assign readDataM = dataMem[wordAddr];  // async read

	always_ff @(posedge Clk) begin
		if (exMem.memWriteM) begin
			dataMem[wordAddr] <= exMem.writeDataM;
		end
	end

	// MEM/WB controls
	always_ff @(posedge Clk) begin
		if (reset) begin
			regWriteW <= 1'b0;
			pcSrcW    <= 1'b0;
			memToRegW <= 1'b0;
		end else begin
			regWriteW <= exMem.regWriteM;
			pcSrcW    <= exMem.pcSrcM;
			memToRegW <= exMem.memToRegM;
		end
	end

	always_ff @(posedge Clk) begin
		readDataW  <= readDataM;
		aluResultW <= exMem.aluResultM;
		wa3W       <= exMem.wa3M;
	end

	assign resultW = memToRegW ? readDataW : aluResultW;

endmodule

//--- verif/exePipeTb.sv
`include "exeSettings.svh"

module exePipeTb;
	timeunit 1ns;
	timeprecision 1ps;
	import exePkg::*;

	localparam int W = `DATA_WIDTH;
	localparam int AB = $clog2(`DMEM_DEPTH);

	typedef struct {
		logic         valid;
		aluOp         op;
		condCode      cond;
		logic [1:0]   flagWrite;
		logic         aluSrc, regWrite, memToReg, memWrite, branch;
		logic [3:0]   ra1, ra2, wa3;
		logic [W-1:0] imm;  // doubles as the MLA accumulator
		logic [W-1:0] expAlu, expResult;
		logic         expTaken, expRegWrite;
		logic [3:0]   expFlags;
	} instrRow;

	logic Clk = 1'b0;
	logic reset, instrValid, regWrite, pcSrc, branch, aluSrc, memToReg, memWrite;
	logic [1:0] flagWrite;
	aluOp aluControl;
	condCode cond;
	logic [W-1:0] dataA, dataB, dataC, ext, aluResult, resultW;
	logic [3:0] wa3, ra1E, ra2E, wa3W, flags;
	logic branchTaken, regWriteW, pcSrcW;

	instrRow rows[$];
	instrRow idle;
	logic [W-1:0] initRegs [16];
	logic [W-1:0] fileRegs [16];  // register file as written back
	int rowErrors[];
	int errorCount = 0;
	int seed = 32'h61d6;
	logic rowsReady = 1'b0;
	logic [3:0] prevFlags = 4'b0;

	exePipeTop exePipeTop_i (.*);

	always #5 Clk = ~Clk;

	function automatic instrRow makeRow(input logic valid, input aluOp op, input condCode cc,
		input logic [1:0] fw, input logic src, rw, m2r, mw, br,
		input logic [3:0] ra1, ra2, wa3, input logic [W-1:0] imm);
		instrRow r;
		r.valid = valid;
		r.op = op;
		r.cond = cc;
		r.flagWrite = fw;
		r.aluSrc = src;
		r.regWrite = rw;
		r.memToReg = m2r;
		r.memWrite = mw;
		r.branch = br;
		r.ra1 = ra1;
		r.ra2 = ra2;
		r.wa3 = wa3;
		r.imm = imm;
		return r;
	endfunction

	// architectural ALU, returns {N, Z, C, V, result}
	function automatic logic [W+3:0] refAlu(input aluOp op, input logic [W-1:0] a, b, c);
		logic [W:0] wide;
		logic [W-1:0] r;
		logic cf;
		logic vf;
		cf = 1'b0;
		vf = 1'b0;
		case (op)
			ADD: begin
				wide = {1'b0, a} + {1'b0, b};
				r = wide[W-1:0];
				cf = wide[W];
				vf = (a[W-1] == b[W-1]) && (r[W-1] != a[W-1]);
			end
			SUB: begin
				r = a - b;
				cf = (a >= b);  // no borrow
				vf = (a[W-1] != b[W-1]) && (r[W-1] != a[W-1]);
			end
			AND: r = a & b;
			ORR: r = a | b;
			EOR: r = a ^ b;
			MOV: r = b;
			MUL: r = a * b;
			MLA: r = a * b + c;
			default: r = '0;
		endcase
		return {r[W-1], r == '0, cf, vf, r};
	endfunction

	function automatic logic condHolds(input condCode cc, input logic [3:0] f);
		logic n, z, c, v;
		{n, z, c, v} = f;
		case (cc)
			EQ: return z;
			NE: return !z;
			CS: return c;
			CC: return !c;
			MI: return n;
			PL: return !n;
			VS: return v;
			VC: return !v;
			HI: return c && !z;
			LS: return !c || z;
			GE: return n == v;
			LT: return n != v;
			GT: return !z && (n == v);
			LE: return z || (n != v);
			default: return 1'b1;
		endcase
	endfunction

	task automatic buildProgram();
		// valid op cond flagWrite aluSrc regWrite memToReg memWrite branch ra1 ra2 wa3 imm
		rows.push_back(makeRow(1, ADD, AL, 2'b11, 0, 1, 0, 0, 0, 4'd2, 4'd3, 4'd1, 0));
		rows.push_back(makeRow(1, SUB, AL, 2'b11, 0, 1, 0, 0, 0, 4'd1, 4'd5, 4'd4, 0));
		rows.push_back(makeRow(1, AND, AL, 2'b00, 0, 1, 0, 0, 0, 4'd7, 4'd1, 4'd6, 0));
		rows.push_back(makeRow(1, ORR, AL, 2'b00, 1, 1, 0, 0, 0, 4'd1, 4'd0, 4'd1, 32'hff00));
		rows.push_back(makeRow(1, EOR, AL, 2'b00, 0, 1, 0, 0, 0, 4'd1, 4'd4, 4'd1, 0));
		rows.push_back(makeRow(1, ADD, AL, 2'b00, 0, 1, 0, 0, 0, 4'd1, 4'd1, 4'd9, 0));
		rows.push_back(makeRow(1, MOV, AL, 2'b00, 1, 1, 0, 0, 0, 4'd0, 4'd0, 4'd10, 7));
		rows.push_back(makeRow(1, MUL, AL, 2'b00, 0, 1, 0, 0, 0, 4'd9, 4'd10, 4'd11, 0));
		rows.push_back(makeRow(1, MLA, AL, 2'b00, 0, 1, 0, 0, 0, 4'd11, 4'd2, 4'd12, 32'h12345678));
		rows.push_back(makeRow(1, SUB, AL, 2'b11, 0, 1, 0, 0, 0, 4'd3, 4'd3, 4'd0, 0));
		rows.push_back(makeRow(1, ADD, EQ, 2'b00, 1, 1, 0, 0, 0, 4'd2, 4'd0, 4'd13, 16));
		rows.push_back(makeRow(1, ADD, NE, 2'b11, 0, 1, 0, 0, 0, 4'd2, 4'd3, 4'd14, 0));
		rows.push_back(makeRow(1, ADD, EQ, 2'b00, 0, 0, 0, 0, 1, 4'd0, 4'd0, 4'd0, 0));
		rows.push_back(makeRow(1, ADD, NE, 2'b00, 0, 0, 0, 0, 1, 4'd0, 4'd0, 4'd0, 0));
		rows.push_back(makeRow(1, MOV, AL, 2'b10, 1, 1, 0, 0, 0, 4'd0, 4'd0, 4'd5, 32'h80000000));
		rows.push_back(makeRow(1, ADD, MI, 2'b01, 0, 1, 0, 0, 0, 4'd6, 4'd7, 4'd6, 0));
		rows.push_back(makeRow(1, SUB, AL, 2'b11, 1, 1, 0, 0, 0, 4'd5, 4'd0, 4'd8, 1));
		rows.push_back(makeRow(1, ADD, LT, 2'b00, 1, 1, 0, 0, 0, 4'd8, 4'd0, 4'd9, 1));
		rows.push_back(makeRow(1, ADD, GE, 2'b00, 1, 1, 0, 0, 0, 4'd8, 4'd0, 4'd10, 1));
		rows.push_back(makeRow(0, ADD, AL, 2'b11, 0, 1, 0, 1, 1, 4'd1, 4'd2, 4'd3, 0));
		rows.push_back(makeRow(1, ADD, AL, 2'b00, 0, 1, 0, 0, 0, 4'd2, 4'd3, 4'd7, 0));
		rows.push_back(makeRow(1, ADD, AL, 2'b00, 1, 0, 0, 1, 0, 4'd2, 4'd7, 4'd0, 32'h40));
		rows.push_back(makeRow(0, ADD, AL, 2'b00, 0, 0, 0, 0, 0, 4'd0, 4'd0, 4'd0, 0));
		rows.push_back(makeRow(1, ADD, AL, 2'b00, 1, 1, 1, 0, 0, 4'd2, 4'd0, 4'd3, 32'h40));
		rows.push_back(makeRow(1, AND, AL, 2'b00, 0, 1, 0, 0, 0, 4'd8, 4'd9, 4'd11, 0));
		rows.push_back(makeRow(1, ADD, AL, 2'b00, 0, 1, 0, 0, 0, 4'd3, 4'd1, 4'd4, 0));
		for (int i = 0; i < 24; i++) begin
			rows.push_back(makeRow(1'b1, aluOp'(4'($unsigned($random(seed)) % 8)),
				condCode'(4'($unsigned($random(seed)) % 15)), 2'($random(seed)),
				1'($random(seed)), 1'b1, 1'b0, 1'b0, 1'($random(seed)),
				4'($unsigned($random(seed)) % 15), 4'($unsigned($random(seed)) % 15),
				4'($unsigned($random(seed)) % 15), $random(seed)));
		end
	endtask

	// fills the expected columns in program order
	task automatic predict();
		logic [W-1:0] regs [16];
		logic [W-1:0] dmem [`DMEM_DEPTH];
		logic [3:0] nzcv;
		logic [W+3:0] out;
		logic [W-1:0] opB;
		logic exec;
		regs = initRegs;
		nzcv = '0;
		foreach (rows[i]) begin
			opB = rows[i].aluSrc ? rows[i].imm : regs[rows[i].ra2];
			out = refAlu(rows[i].op, regs[rows[i].ra1], opB, rows[i].imm);
			exec = rows[i].valid && condHolds(rows[i].cond, nzcv);
			rows[i].expAlu = out[W-1:0];
			rows[i].expTaken = rows[i].branch && exec;
			rows[i].expRegWrite = rows[i].regWrite && exec;
			rows[i].expResult = rows[i].memToReg ? dmem[out[AB+1:2]] : out[W-1:0];
			if (exec) begin
				if (rows[i].flagWrite[1]) nzcv[3:2] = out[W+3:W+2];
				if (rows[i].flagWrite[0]) nzcv[1:0] = out[W+1:W];
				if (rows[i].memWrite) dmem[out[AB+1:2]] = regs[rows[i].ra2];
				if (rows[i].regWrite) regs[rows[i].wa3] = rows[i].expResult;
			end
			rows[i].expFlags = nzcv;
		end
	endtask

	task automatic drive(input instrRow r);
		instrValid <= r.valid;
		regWrite <= r.regWrite;
		pcSrc <= r.branch;
		branch <= r.branch;
		aluSrc <= r.aluSrc;
		memToReg <= r.memToReg;
		memWrite <= r.memWrite;
		flagWrite <= r.flagWrite;
		aluControl <= r.op;
		cond <= r.cond;
		dataA <= fileRegs[r.ra1];
		dataB <= fileRegs[r.ra2];
		dataC <= r.imm;
		ext <= r.imm;
		wa3 <= r.wa3;
		ra1E <= r.ra1;
		ra2E <= r.ra2;
	endtask

	task automatic checkEq(input string what, input int rowNum, input logic [W-1:0] got, exp);
		assert (got === exp) else begin
			$display("FAILED %0t: row %0d %s is %h, expected %h", $time, rowNum, what, got, exp);
			errorCount++;
			if (rowNum >= 0) rowErrors[rowNum]++;
		end
	endtask

	initial begin
		int n;
		int wbRow;
		int failedRows;
		failedRows = 0;
		foreach (initRegs[i]) initRegs[i] = $random(seed);
		fileRegs = initRegs;
		buildProgram();
		predict();
		n = rows.size();
		rowErrors = new[n];
		idle = makeRow(0, ADD, AL, 2'b00, 0, 0, 0, 0, 0, 4'd0, 4'd0, 4'd0, 0);
		reset = 1'b1;
		drive(idle);
		rowsReady = 1'b1;
		repeat (3) @(posedge Clk);
		reset <= 1'b0;
		for (int k = 0; k < n + 2; k++) begin
			@(posedge Clk);
			if (k >= 3) begin
				if (rows[k-3].expRegWrite) fileRegs[rows[k-3].wa3] = rows[k-3].expResult;
			end
			if (k < n) drive(rows[k]);
			else drive(idle);
			@(negedge Clk);
			if (k < n) begin
				checkEq("aluResult", k, aluResult, rows[k].expAlu);
				checkEq("branchTaken", k, branchTaken, rows[k].expTaken);
			end
			checkEq("flags", k - 1, flags, prevFlags);
			wbRow = k - 2;
			if (wbRow < 0) begin
				checkEq("regWriteW", wbRow, regWriteW, 0);  // still reset
				checkEq("pcSrcW", wbRow, pcSrcW, 0);
			end else begin
				checkEq("regWriteW", wbRow, regWriteW, rows[wbRow].expRegWrite);
				checkEq("pcSrcW", wbRow, pcSrcW, rows[wbRow].expTaken);
				if (rows[wbRow].expRegWrite) begin
					checkEq("resultW", wbRow, resultW, rows[wbRow].expResult);
					checkEq("wa3W", wbRow, wa3W, rows[wbRow].wa3);
				end
				if (rowErrors[wbRow] != 0) failedRows++;
				$display("row %0d %s %s: %s", wbRow, rows[wbRow].op.name(),
					rows[wbRow].cond.name(), rowErrors[wbRow] == 0 ? "passed" : "failed");
			end
			if (k < n) prevFlags = rows[k].expFlags;
		end
		$display("%0d rows, %0d passed, %0d failed, %0d errors", n, n - failedRows,
			failedRows, errorCount);
		if (errorCount == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	// watchdog sized from the table
	initial begin
		wait (rowsReady);
		#((rows.size() + 20) * 10);
		$display("timeout: the instruction table did not finish in time");
		$display("** FAIL **");
		$finish;
	end

endmodule
